/* verilog/fir_pkg.sv */
`default_nettype none

package fir_pkg;

    // bus and sample widths
    localparam int addr_w = 12;
    localparam int data_w = 32;

    typedef logic [addr_w-1:0] addr_t;
    // samples and coefficients are signed, arithmetic wraps at 32 bits
    typedef logic signed [data_w-1:0] word_t;

    // register map
    localparam addr_t reg_ctrl   = 12'h000;
    localparam addr_t reg_length = 12'h010;
    localparam addr_t tap_base   = 12'h020;

    // control register bits
    localparam int ctrl_start = 0;
    localparam int ctrl_done  = 1;
    localparam int ctrl_idle  = 2;

endpackage

`default_nettype wire

/* verilog/fir_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fir_ctrl_if import fir_pkg::*; #(
    parameter int num_taps = 11
);

    localparam int aw = num_taps > 1 ? $clog2(num_taps) : 1;

    // run control
    logic          start;
    word_t         length;
    logic          done;

    // tap coefficient lookup, one cycle of read latency
    logic [aw-1:0] tap_addr;
    word_t         tap_coef;

    modport regs (
        output start,
        output length,
        output tap_coef,
        input  done,
        input  tap_addr
    );

    modport engine (
        input  start,
        input  length,
        input  tap_coef,
        output done,
        output tap_addr
    );

endinterface

`default_nettype wire

/* verilog/word_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module word_ram import fir_pkg::*; #(
    parameter int depth = 16,
    parameter int width = data_w,
    localparam int aw = depth > 1 ? $clog2(depth) : 1
) (
    input  logic          axis_clk,
    input  logic          we,
    input  logic [aw-1:0] waddr,
    input  word_t         wdata,
    input  logic [aw-1:0] raddr,
    output word_t         rdata
);

    logic [width-1:0] mem [depth];

    // registered read returns the old word on a write to the same address
    always_ff @(posedge axis_clk) begin
        if (we) begin
            mem[waddr] <= width'(wdata);
        end
        rdata <= word_t'(mem[raddr]);
    end

    // callers must keep write indices inside the array
    assert property (@(posedge axis_clk) we |-> int'(waddr) < depth)
        else $error("word_ram write address %0d beyond depth %0d", waddr, depth);

endmodule

`default_nettype wire

/* verilog/fir_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_regs import fir_pkg::*; #(
    parameter int num_taps = 11
) (
    input  logic     axis_clk,
    input  logic     axis_rst_n,
    input  logic     awvalid,
    output logic     awready,
    input  addr_t    awaddr,
    input  logic     wvalid,
    output logic     wready,
    input  word_t    wdata,
    output logic     bvalid,
    input  logic     bready,
    input  logic     arvalid,
    output logic     arready,
    input  addr_t    araddr,
    output logic     rvalid,
    input  logic     rready,
    output word_t    rdata,
    fir_ctrl_if.regs ctrl
);

    localparam int aw = num_taps > 1 ? $clog2(num_taps) : 1;

    logic          idle_r;
    logic          done_r;
    word_t         length_r;
    logic          wr_take;
    logic          rd_take;
    logic          rd_pend;
    logic          rd_busy;
    addr_t         rd_addr;
    word_t         rd_mux;
    logic          tap_we;
    logic [aw-1:0] tap_waddr;
    logic [aw-1:0] tap_raddr;
    word_t         tap_rdata;
    logic          run_seen;

    // word aligned and inside the coefficient window
    function automatic logic tap_hit(addr_t a);
        return int'(a) >= int'(tap_base) && int'(a) < int'(tap_base) + 4 * num_taps &&
               a[1:0] == 2'b00;
    endfunction

    function automatic logic [aw-1:0] tap_index(addr_t a);
        addr_t off;
        off = a - tap_base;
        return off[aw+1:2];
    endfunction

    // write channel takes address and data together
    assign awready = !bvalid;
    assign wready  = !bvalid;
    assign wr_take = awvalid && wvalid && !bvalid;

    // tap writes during a run are acknowledged but dropped
    assign tap_we    = wr_take && idle_r && tap_hit(awaddr);
    assign tap_waddr = tap_index(awaddr);

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            bvalid     <= 1'b0;
            ctrl.start <= 1'b0;
            idle_r     <= 1'b1;
            done_r     <= 1'b0;
            length_r   <= '0;
        end else begin
            ctrl.start <= 1'b0;
            if (wr_take) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (ctrl.done) begin
                done_r <= 1'b1;
                idle_r <= 1'b1;
            end
            if (wr_take && awaddr == reg_ctrl && wdata[ctrl_start] && idle_r) begin
                ctrl.start <= 1'b1;
                idle_r     <= 1'b0;
                done_r     <= 1'b0;
            end
            if (wr_take && awaddr == reg_length) begin
                length_r <= wdata;
            end
        end
    end

    assign ctrl.length = length_r;

    // read channel with a fixed two cycle latency
    assign arready = !rd_pend && !rvalid;
    assign rd_take = arvalid && arready;

    // engine owns the tap read port while a run is active
    assign tap_raddr = !idle_r ? ctrl.tap_addr :
                       (tap_hit(araddr) ? tap_index(araddr) : '0);
    assign ctrl.tap_coef = tap_rdata;

    always_comb begin
        rd_mux = '0;
        if (rd_addr == reg_ctrl) begin
            rd_mux[ctrl_done] = done_r;
            rd_mux[ctrl_idle] = idle_r;
        end else if (rd_addr == reg_length) begin
            rd_mux = length_r;
        end else if (tap_hit(rd_addr) && !rd_busy) begin
            rd_mux = tap_rdata;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            rd_pend <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            rd_pend <= rd_take;
            if (rd_pend) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (rd_take) begin
            rd_addr <= araddr;
            // taps read as zero if the port belonged to the engine
            rd_busy <= !idle_r;
        end
        if (rd_pend) begin
            rdata <= rd_mux;
        end
    end

    // run in flight from the start pulse until the engine reports done
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            run_seen <= 1'b0;
        end else if (ctrl.start) begin
            run_seen <= 1'b1;
        end else if (ctrl.done) begin
            run_seen <= 1'b0;
        end
    end

    word_ram #(
        .depth (num_taps),
        .width (data_w)
    ) tap_ram (
        .axis_clk (axis_clk),
        .we       (tap_we),
        .waddr    (tap_waddr),
        .wdata    (wdata),
        .raddr    (tap_raddr),
        .rdata    (tap_rdata)
    );

    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("read data moved before rready");

    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        ctrl.start |-> !run_seen)
        else $error("start pulse while a run is active");

endmodule

`default_nettype wire

/* verilog/fir_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_engine import fir_pkg::*; #(
    parameter int num_taps = 11
) (
    input  logic       axis_clk,
    input  logic       axis_rst_n,
    input  logic       ss_tvalid,
    output logic       ss_tready,
    input  word_t      ss_tdata,
    output logic       sm_tvalid,
    input  logic       sm_tready,
    output word_t      sm_tdata,
    output logic       sm_tlast,
    fir_ctrl_if.engine ctrl
);

    localparam int aw = num_taps > 1 ? $clog2(num_taps) : 1;
    localparam int kw = $clog2(num_taps + 1);
    localparam logic [aw-1:0] last_slot = aw'(num_taps - 1);

    typedef enum logic [2:0] {
        s_idle,
        s_clear,
        s_wait,
        s_mac,
        s_out
    } state_t;

    state_t            state;
    logic [kw-1:0]     kk;
    logic [aw-1:0]     k_idx;
    logic [aw-1:0]     wptr;
    logic [aw-1:0]     rslot;
    logic [data_w-1:0] len_r;
    logic [data_w-1:0] scnt;
    logic              take;
    logic              issue;
    word_t             acc;
    word_t             prod;
    logic              hist_we;
    logic [aw-1:0]     hist_waddr;
    word_t             hist_wdata;
    word_t             hist_rdata;

    assign ss_tready = state == s_wait;
    assign take      = ss_tvalid && ss_tready;

    // kk walks the taps, then one extra cycle drains the read pipeline
    assign issue = state == s_mac && int'(kk) < num_taps;
    assign k_idx = int'(kk) < num_taps ? aw'(kk) : '0;
    assign ctrl.tap_addr = k_idx;

    // history writes: zero fill during clear, new samples otherwise
    assign hist_we    = state == s_clear || take;
    assign hist_waddr = state == s_clear ? k_idx : wptr;
    assign hist_wdata = state == s_clear ? '0 : ss_tdata;

    assign prod = ctrl.tap_coef * hist_rdata;

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            state     <= s_idle;
            kk        <= '0;
            wptr      <= '0;
            rslot     <= '0;
            scnt      <= '0;
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
            ctrl.done <= 1'b0;
        end else begin
            ctrl.done <= 1'b0;
            case (state)
                s_idle: begin
                    if (ctrl.start) begin
                        state <= s_clear;
                        kk    <= '0;
                        wptr  <= '0;
                        scnt  <= '0;
                    end
                end
                s_clear: begin
                    if (int'(kk) == num_taps - 1) begin
                        kk <= '0;
                        // empty run finishes straight after the clear
                        if (len_r == '0) begin
                            ctrl.done <= 1'b1;
                            state     <= s_idle;
                        end else begin
                            state <= s_wait;
                        end
                    end else begin
                        kk <= kk + 1'b1;
                    end
                end
                s_wait: begin
                    if (take) begin
                        state <= s_mac;
                        kk    <= '0;
                        rslot <= wptr;
                        wptr  <= wptr == last_slot ? '0 : wptr + 1'b1;
                        scnt  <= scnt + 1'b1;
                    end
                end
                s_mac: begin
                    // step back one slot per tap, wrapping around the ring
                    if (issue) begin
                        rslot <= rslot == '0 ? last_slot : rslot - 1'b1;
                    end
                    if (int'(kk) == num_taps) begin
                        state     <= s_out;
                        sm_tvalid <= 1'b1;
                        sm_tlast  <= scnt == len_r;
                    end else begin
                        kk <= kk + 1'b1;
                    end
                end
                s_out: begin
                    if (sm_tready) begin
                        sm_tvalid <= 1'b0;
                        sm_tlast  <= 1'b0;
                        if (sm_tlast) begin
                            ctrl.done <= 1'b1;
                            state     <= s_idle;
                        end else begin
                            state <= s_wait;
                        end
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        if (state == s_idle && ctrl.start) begin
            len_r <= ctrl.length;
        end
        if (take) begin
            acc <= '0;
        end else if (state == s_mac && kk != '0) begin
            acc <= acc + prod;
        end
        // last product lands directly in the output register
        if (state == s_mac && int'(kk) == num_taps) begin
            sm_tdata <= acc + prod;
        end
    end

    word_ram #(
        .depth (num_taps),
        .width (data_w)
    ) hist_ram (
        .axis_clk (axis_clk),
        .we       (hist_we),
        .waddr    (hist_waddr),
        .wdata    (hist_wdata),
        .raddr    (rslot),
        .rdata    (hist_rdata)
    );

    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast))
        else $error("output stream changed while stalled");

endmodule

`default_nettype wire

/* verilog/fir_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_top import fir_pkg::*; #(
    parameter int num_taps = 11
) (
    input  logic  axis_clk,
    input  logic  axis_rst_n,
    // AXI4-Lite configuration
    input  logic  awvalid,
    output logic  awready,
    input  addr_t awaddr,
    input  logic  wvalid,
    output logic  wready,
    input  word_t wdata,
    output logic  bvalid,
    input  logic  bready,
    input  logic  arvalid,
    output logic  arready,
    input  addr_t araddr,
    output logic  rvalid,
    input  logic  rready,
    output word_t rdata,
    // AXI4-Stream samples in
    input  logic  ss_tvalid,
    output logic  ss_tready,
    input  word_t ss_tdata,
    // AXI4-Stream results out
    output logic  sm_tvalid,
    input  logic  sm_tready,
    output word_t sm_tdata,
    output logic  sm_tlast
);

    fir_ctrl_if #(.num_taps(num_taps)) ctrl_bus ();

    fir_regs #(
        .num_taps (num_taps)
    ) u_regs (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .bvalid     (bvalid),
        .bready     (bready),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ctrl       (ctrl_bus.regs)
    );

    fir_engine #(
        .num_taps (num_taps)
    ) u_engine (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .ss_tvalid  (ss_tvalid),
        .ss_tready  (ss_tready),
        .ss_tdata   (ss_tdata),
        .sm_tvalid  (sm_tvalid),
        .sm_tready  (sm_tready),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .ctrl       (ctrl_bus.engine)
    );

endmodule

`default_nettype wire

/* bench/fir_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_clkgen #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 2
) (
    output logic axis_clk,
    output logic axis_rst_n
);

    initial begin
        axis_clk = 1'b0;
        forever #(half_period) axis_clk = ~axis_clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        axis_rst_n = 1'b0;
        repeat (reset_cycles) @(posedge axis_clk);
        @(negedge axis_clk);
        axis_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* bench/fir_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_tb import fir_pkg::*; ();

    localparam int num_taps       = 11;
    localparam int stress_len     = 40;
    localparam int second_len     = 15;
    localparam int timeout_cycles = (stress_len + second_len) * (num_taps + 6) + 2000;

    logic   axis_clk;
    logic   axis_rst_n;
    logic   awvalid;
    logic   awready;
    addr_t  awaddr;
    logic   wvalid;
    logic   wready;
    word_t  wdata;
    logic   bvalid;
    logic   bready;
    logic   arvalid;
    logic   arready;
    addr_t  araddr;
    logic   rvalid;
    logic   rready;
    word_t  rdata;
    logic   ss_tvalid;
    logic   ss_tready;
    word_t  ss_tdata;
    logic   sm_tvalid;
    logic   sm_tready;
    word_t  sm_tdata;
    logic   sm_tlast;

    integer seed;
    string  cur_test;
    int     errors;
    int     test_errors;
    int     tests_ok;
    int     tests_bad;
    word_t  taps [num_taps];
    word_t  samples [$];
    word_t  rd_val;
    word_t  mid_val;
    logic   poll_done;
    int     stray_out;

    fir_clkgen clkgen (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n)
    );

    fir_top #(
        .num_taps (num_taps)
    ) uut (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .bvalid     (bvalid),
        .bready     (bready),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tready  (ss_tready),
        .ss_tdata   (ss_tdata),
        .sm_tvalid  (sm_tvalid),
        .sm_tready  (sm_tready),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast)
    );

    // expected output n as the sum of tap k times sample n-k with older samples as zero
    function automatic word_t fir_ref(int n);
        word_t acc;
        acc = '0;
        for (int k = 0; k < num_taps; k++) begin
            if (n - k >= 0) begin
                acc = acc + taps[k] * samples[n - k];
            end
        end
        return acc;
    endfunction

    function automatic addr_t tap_address(int k);
        return tap_base + addr_t'(4 * k);
    endfunction

    task automatic check_value(input string what, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            $display("ERR %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            tests_ok++;
            $display("test %s: ok", cur_test);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", cur_test, errors - test_errors);
        end
    endtask

    // all bus tasks start and end on a falling edge
    task automatic axi_write(input addr_t addr, input word_t data);
        logic taken;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        taken   = 1'b0;
        while (!taken) begin
            taken = awready && wready;
            @(negedge axis_clk);
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge axis_clk);
        @(negedge axis_clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input addr_t addr, output word_t data);
        logic taken;
        araddr  = addr;
        arvalid = 1'b1;
        taken   = 1'b0;
        while (!taken) begin
            taken = arready;
            @(negedge axis_clk);
        end
        arvalid = 1'b0;
        while (!rvalid) @(negedge axis_clk);
        data   = rdata;
        rready = 1'b1;
        @(negedge axis_clk);
        rready = 1'b0;
    endtask

    task automatic load_taps();
        for (int k = 0; k < num_taps; k++) begin
            taps[k] = $random(seed);
            axi_write(tap_address(k), taps[k]);
        end
    endtask

    task automatic make_samples(input int n);
        samples.delete();
        for (int i = 0; i < n; i++) begin
            samples.push_back($random(seed));
        end
    endtask

    // random idle cycles where valid only drops after a transfer
    task automatic stream_send(input int n);
        int   idx;
        logic fire;
        idx = 0;
        while (idx < n) begin
            if (!ss_tvalid && ($random(seed) & 3) == 0) begin
                ss_tvalid = 1'b0;
            end else begin
                ss_tvalid = 1'b1;
                ss_tdata  = samples[idx];
            end
            fire = ss_tvalid && ss_tready;
            @(negedge axis_clk);
            if (fire) begin
                idx++;
                ss_tvalid = 1'b0;
            end
        end
    endtask

    // output is stable between rising edges and is compared at the falling edge
    task automatic stream_check(input int n);
        int got;
        got = 0;
        while (got < n) begin
            sm_tready = ($random(seed) & 3) != 0;
            if (sm_tvalid && sm_tready) begin
                check_value($sformatf("output %0d", got), fir_ref(got), sm_tdata);
                check_value($sformatf("tlast %0d", got), word_t'(got == n - 1),
                            word_t'(sm_tlast));
                got++;
            end
            @(negedge axis_clk);
        end
        sm_tready = 1'b0;
    endtask

    initial begin : watchdog
        repeat (timeout_cycles) @(posedge axis_clk);
        $display("timeout: test %s did not finish within %0d cycles", cur_test, timeout_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        bready    = 1'b0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        ss_tvalid = 1'b0;
        ss_tdata  = '0;
        sm_tready = 1'b0;
        seed      = 32'haffffc26;
        errors    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        cur_test  = "reset";
        wait (axis_rst_n === 1'b1);
        @(negedge axis_clk);

        begin_test("reset");
        check_value("sm_tvalid", 0, word_t'(sm_tvalid));
        check_value("awready", 1, word_t'(awready));
        check_value("wready", 1, word_t'(wready));
        check_value("arready", 1, word_t'(arready));
        axi_read(reg_ctrl, rd_val);
        check_value("ctrl", 4, rd_val);
        axi_read(reg_length, rd_val);
        check_value("length", 0, rd_val);
        end_test();

        begin_test("readback");
        load_taps();
        axi_write(reg_length, stress_len);
        for (int k = 0; k < num_taps; k++) begin
            axi_read(tap_address(k), rd_val);
            check_value($sformatf("tap %0d", k), taps[k], rd_val);
        end
        axi_read(reg_length, rd_val);
        check_value("length", stress_len, rd_val);
        end_test();

        begin_test("stress");
        make_samples(stress_len);
        axi_write(reg_ctrl, 32'h1);
        fork
            stream_send(stress_len);
            stream_check(stress_len);
            begin
                // tap access while the engine owns the tap RAM
                repeat (60) @(negedge axis_clk);
                axi_write(tap_address(3), 32'h5a5a_0001);
                axi_read(tap_address(0), mid_val);
                check_value("tap read during run", 0, mid_val);
            end
        join
        end_test();

        begin_test("status");
        axi_read(reg_ctrl, rd_val);
        check_value("ctrl", 6, rd_val);
        axi_read(tap_address(3), rd_val);
        check_value("tap 3", taps[3], rd_val);
        end_test();

        begin_test("second");
        load_taps();
        axi_write(reg_length, second_len);
        make_samples(second_len);
        axi_write(reg_ctrl, 32'h1);
        fork
            stream_send(second_len);
            stream_check(second_len);
        join
        end_test();

        begin_test("empty");
        axi_write(reg_length, 0);
        axi_write(reg_ctrl, 32'h1);
        poll_done = 1'b0;
        stray_out = 0;
        fork
            begin
                rd_val = '0;
                while (!rd_val[ctrl_idle]) axi_read(reg_ctrl, rd_val);
                poll_done = 1'b1;
            end
            begin
                sm_tready = 1'b1;
                while (!poll_done) begin
                    if (sm_tvalid) stray_out++;
                    @(negedge axis_clk);
                end
                sm_tready = 1'b0;
            end
        join
        check_value("ctrl", 6, rd_val);
        assert (stray_out == 0) else begin
            $display("%s: %0d output transfers seen in a run of length zero",
                     cur_test, stray_out);
            errors++;
        end
        end_test();

        $display("summary: passed tests %0d, failed tests %0d, check errors %0d",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
verilog/fir_pkg.sv
verilog/fir_ctrl_if.sv
verilog/word_ram.sv
verilog/fir_regs.sv
verilog/fir_engine.sv
verilog/fir_top.sv
bench/fir_clkgen.sv
bench/fir_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fir_tb -f sources.f -o fir_sim

./obj_dir/fir_sim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
grep -q "TESTS PASSED" sim.log
